//--- design/collide_pkg.sv
package collide_pkg;

	// coordinate and radius width
	localparam int COORD_W = 16;

	// three squared 17-bit differences
	localparam int DIST_SQ_W = 34;

	// r_a + r_b needs one extra bit
	localparam int RSUM_W = 17;

	typedef logic signed [COORD_W-1:0] coord_t;

	// radius is non-negative, same type as the centre
	typedef struct packed {
		coord_t x;
		coord_t y;
		coord_t z;
		coord_t r;
	} sphere_t;

	typedef struct packed {
		sphere_t a;
		sphere_t b;
	} collide_req_t;

	// geometry handed from the distance pipeline to the controller
	typedef struct packed {
		logic [DIST_SQ_W-1:0] dist_sq;
		logic [RSUM_W-1:0]    rsum;
		logic [DIST_SQ_W-1:0] rsum_sq;
	} geom_t;

	typedef enum logic [1:0] {
		NO_CONTACT,
		CONCENTRIC,
		TOUCHING
	} contact_kind_e;

	typedef struct packed {
		contact_kind_e     kind;
		logic [RSUM_W-1:0] depth;
	} collide_res_t;

	typedef enum logic [1:0] {
		IDLE,
		CLASSIFY,
		ROOT_WAIT,
		HOLD
	} ctrl_state_e;

endpackage

//--- design/dist_sq_unit.sv
`timescale 1ns/1ns

module dist_sq_unit (
	input  logic                      clk,
	input  logic                      clk0,
	input  collide_pkg::collide_req_t req,
	input  logic                      req_valid,
	output logic                      req_ready,
	output collide_pkg::geom_t        geom,
	output logic                      geom_valid,
	input  logic                      geom_ready
);
	import collide_pkg::*;

	logic                     init_done;
	logic                     advance;
	logic                     s1_valid;
	logic                     s2_valid;
	logic signed [COORD_W:0]  s1_dx;
	logic signed [COORD_W:0]  s1_dy;
	logic signed [COORD_W:0]  s1_dz;
	logic [RSUM_W-1:0]        s1_rsum;
	logic [DIST_SQ_W-1:0]     rsum_wide;
	logic [DIST_SQ_W-1:0]     sum_sq;
	geom_t                    s2_geom;

	// sign-extend both sides, the difference needs COORD_W+1 bits
	function automatic logic signed [COORD_W:0] axis_diff(input coord_t p, input coord_t q);
		return {p[COORD_W-1], p} - {q[COORD_W-1], q};
	endfunction

	function automatic logic [DIST_SQ_W-1:0] square(input logic signed [COORD_W:0] v);
		logic signed [DIST_SQ_W-1:0] p;
		p = v * v;
		return p;
	endfunction

	// whole pipe moves when stage 2 is empty or being drained
	assign advance   = !s2_valid || geom_ready;
	assign req_ready = init_done && advance;

	always_comb
	begin
		rsum_wide = DIST_SQ_W'(s1_rsum);
		sum_sq    = square(s1_dx) + square(s1_dy) + square(s1_dz);
	end

	// readiness flag, one cycle after reset release
	always_ff @(posedge clk or posedge clk0)
	begin
		if (clk0)
		begin
			init_done <= 1'b0;
			s1_valid  <= 1'b0;
			s2_valid  <= 1'b0;
		end
		else
		begin
			init_done <= 1'b1;
			if (advance)
			begin
				s1_valid <= req_valid && req_ready;
				s2_valid <= s1_valid;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (advance)
		begin
			// stage 1: axis differences and radius sum
			s1_dx   <= axis_diff(req.a.x, req.b.x);
			s1_dy   <= axis_diff(req.a.y, req.b.y);
			s1_dz   <= axis_diff(req.a.z, req.b.z);
			s1_rsum <= {1'b0, req.a.r} + {1'b0, req.b.r};
			// stage 2: squared sums
			s2_geom.dist_sq <= sum_sq;
			s2_geom.rsum    <= s1_rsum;
			s2_geom.rsum_sq <= rsum_wide * rsum_wide;
		end
	end

	assign geom       = s2_geom;
	assign geom_valid = s2_valid;

	// geometry held until the controller takes it
	assert property (@(posedge clk) disable iff (clk0)
		geom_valid && !geom_ready |=> geom_valid && $stable(geom));

endmodule

//--- design/isqrt_seq.sv
`timescale 1ns/1ns

module isqrt_seq #(
	parameter int RADICAND_W = 34
) (
	input  logic                    clk,
	input  logic                    clk0,
	input  logic                    root_start,
	input  logic [RADICAND_W-1:0]   radicand,
	output logic                    root_busy,
	output logic                    root_done,
	output logic [RADICAND_W/2-1:0] root
);
	localparam int HALF  = RADICAND_W / 2;
	localparam int CNT_W = $clog2(HALF + 1);

	logic [CNT_W-1:0]      cnt;
	logic [RADICAND_W-1:0] rad;
	logic [HALF:0]         rem;
	logic [HALF-1:0]       q;
	logic [HALF:0]         step_rem_in;
	logic [HALF-1:0]       step_q_in;
	logic [1:0]            step_bits;
	logic [HALF+2:0]       rem_sh;
	logic [HALF+2:0]       trial;
	logic [HALF:0]         rem_next;
	logic [HALF-1:0]       q_next;

	// one restoring step, shared by the start cycle and the busy cycles
	always_comb
	begin
		if (root_start)
		begin
			step_rem_in = '0;
			step_q_in   = '0;
			step_bits   = radicand[RADICAND_W-1 -: 2];
		end
		else
		begin
			step_rem_in = rem;
			step_q_in   = q;
			step_bits   = rad[RADICAND_W-1 -: 2];
		end
		rem_sh = {step_rem_in, step_bits};
		trial  = {1'b0, step_q_in, 2'b01};
		// remainder can reach twice the partial root, HALF+1 bits
		if (rem_sh >= trial)
		begin
			rem_next = (HALF+1)'(rem_sh - trial);
			q_next   = {step_q_in[HALF-2:0], 1'b1};
		end
		else
		begin
			rem_next = (HALF+1)'(rem_sh);
			q_next   = {step_q_in[HALF-2:0], 1'b0};
		end
	end

	always_ff @(posedge clk or posedge clk0)
	begin
		if (clk0)
		begin
			cnt       <= '0;
			root_busy <= 1'b0;
			root_done <= 1'b0;
		end
		else
		begin
			root_done <= 1'b0;
			if (root_start)
			begin
				cnt       <= CNT_W'(HALF - 1);
				root_busy <= (HALF > 1);
				root_done <= (HALF == 1);
			end
			else if (root_busy)
			begin
				cnt <= cnt - 1'b1;
				// last bit decided on this edge
				if (cnt == CNT_W'(1))
				begin
					root_busy <= 1'b0;
					root_done <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (root_start || root_busy)
		begin
			rem <= rem_next;
			q   <= q_next;
		end
		if (root_start)
			rad <= radicand << 2;
		else if (root_busy)
			rad <= rad << 2;
	end

	assign root = q;

	assert property (@(posedge clk) disable iff (clk0)
		root_start |-> !root_busy);

	assert property (@(posedge clk) disable iff (clk0)
		root_done |=> !root_done);

endmodule

//--- design/collide_ctrl.sv
`timescale 1ns/1ns

module collide_ctrl (
	input  logic                                 clk,
	input  logic                                 clk0,
	input  collide_pkg::geom_t                   geom,
	input  logic                                 geom_valid,
	output logic                                 geom_ready,
	output logic                                 root_start,
	output logic [collide_pkg::DIST_SQ_W-1:0]    radicand,
	input  logic                                 root_busy,
	input  logic                                 root_done,
	input  logic [collide_pkg::RSUM_W-1:0]       root,
	output collide_pkg::collide_res_t            res,
	output logic                                 res_valid,
	input  logic                                 res_ready
);
	import collide_pkg::*;

	ctrl_state_e  state;
	geom_t        geom_q;
	collide_res_t res_q;
	logic         no_contact;
	logic         concentric;
	logic         need_root;

	always_comb
	begin
		no_contact = geom_q.dist_sq > geom_q.rsum_sq;
		concentric = geom_q.dist_sq == '0;
		need_root  = !no_contact && !concentric;
	end

	assign geom_ready = (state == IDLE);
	assign root_start = (state == CLASSIFY) && need_root && !root_busy;
	assign radicand   = geom_q.dist_sq;
	assign res        = res_q;
	assign res_valid  = (state == HOLD);

	always_ff @(posedge clk or posedge clk0)
	begin
		if (clk0)
			state <= IDLE;
		else
		begin
			case (state)
				IDLE:
				begin
					if (geom_valid)
						state <= CLASSIFY;
				end
				CLASSIFY:
				begin
					if (!need_root)
						state <= HOLD;
					else if (!root_busy)
						state <= ROOT_WAIT;
				end
				ROOT_WAIT:
				begin
					if (root_done)
						state <= HOLD;
				end
				HOLD:
				begin
					if (res_ready)
						state <= IDLE;
				end
				default:
					state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (geom_valid && geom_ready)
			geom_q <= geom;
		if (state == CLASSIFY)
		begin
			if (no_contact)
			begin
				res_q.kind  <= NO_CONTACT;
				res_q.depth <= '0;
			end
			else if (concentric)
			begin
				res_q.kind  <= CONCENTRIC;
				res_q.depth <= geom_q.rsum;
			end
		end
		// root <= rsum here since dist_sq <= rsum_sq
		if (state == ROOT_WAIT && root_done)
		begin
			res_q.kind  <= TOUCHING;
			res_q.depth <= geom_q.rsum - root;
		end
	end

	assert property (@(posedge clk) disable iff (clk0)
		res_valid && !res_ready |=> res_valid && $stable(res));

	assert property (@(posedge clk) disable iff (clk0)
		res_valid |-> res.depth <= geom_q.rsum);

endmodule

//--- design/sphere_collide_top.sv
`timescale 1ns/1ns

module sphere_collide_top (
	input  logic                      clk,
	input  logic                      clk0,
	input  collide_pkg::collide_req_t req,
	input  logic                      req_valid,
	output logic                      req_ready,
	output collide_pkg::collide_res_t res,
	output logic                      res_valid,
	input  logic                      res_ready
);
	import collide_pkg::*;

	geom_t                geom;
	logic                 geom_valid;
	logic                 geom_ready;
	logic                 root_start;
	logic [DIST_SQ_W-1:0] radicand;
	logic                 root_busy;
	logic                 root_done;
	logic [RSUM_W-1:0]    root;

	// squared distance and radius sum
	dist_sq_unit u_dist (
		.clk        (clk),
		.clk0       (clk0),
		.req        (req),
		.req_valid  (req_valid),
		.req_ready  (req_ready),
		.geom       (geom),
		.geom_valid (geom_valid),
		.geom_ready (geom_ready)
	);

	collide_ctrl u_ctrl (
		.clk        (clk),
		.clk0       (clk0),
		.geom       (geom),
		.geom_valid (geom_valid),
		.geom_ready (geom_ready),
		.root_start (root_start),
		.radicand   (radicand),
		.root_busy  (root_busy),
		.root_done  (root_done),
		.root       (root),
		.res        (res),
		.res_valid  (res_valid),
		.res_ready  (res_ready)
	);

	// root width is half the squared-distance width
	isqrt_seq #(
		.RADICAND_W (DIST_SQ_W)
	) u_root (
		.clk        (clk),
		.clk0       (clk0),
		.root_start (root_start),
		.radicand   (radicand),
		.root_busy  (root_busy),
		.root_done  (root_done),
		.root       (root)
	);

endmodule

//--- tb/tb_sphere_collide.sv
`timescale 1ns/1ns

module tb_sphere_collide;
	import collide_pkg::*;

	localparam int READY_LIMIT  = 200;
	localparam int RESULT_LIMIT = 600;
	localparam int QUIET_CYCLES = 40;

	typedef struct packed {
		collide_req_t req;
		collide_res_t expected;
	} vector_t;

	logic         clk;
	logic         clk0;
	collide_req_t req;
	logic         req_valid;
	logic         req_ready;
	collide_res_t res;
	logic         res_valid;
	logic         res_ready;
	vector_t      vectors[$];
	int           error_count;

	sphere_collide_top i_dut (
		.clk       (clk),
		.clk0      (clk0),
		.req       (req),
		.req_valid (req_valid),
		.req_ready (req_ready),
		.res       (res),
		.res_valid (res_valid),
		.res_ready (res_ready)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic sphere_t make_sphere(int x, int y, int z, int r);
		sphere_t s;
		s.x = coord_t'(x);
		s.y = coord_t'(y);
		s.z = coord_t'(z);
		s.r = coord_t'(r);
		return s;
	endfunction

	task automatic add_row(sphere_t a, sphere_t b, contact_kind_e kind, int depth);
		vector_t v;
		v.req.a          = a;
		v.req.b          = b;
		v.expected.kind  = kind;
		v.expected.depth = RSUM_W'(depth);
		vectors.push_back(v);
	endtask

	// expected values worked out by hand
	task automatic load_table();
		add_row(make_sphere(0, 0, 0, 5), make_sphere(100, 0, 0, 5), NO_CONTACT, 0);
		// squared distance 26 against 25
		add_row(make_sphere(10, 20, 30, 2), make_sphere(14, 23, 31, 3), NO_CONTACT, 0);
		add_row(make_sphere(7, -8, 9, 10), make_sphere(7, -8, 9, 25), CONCENTRIC, 35);
		add_row(make_sphere(0, 0, 0, 0), make_sphere(0, 0, 0, 0), CONCENTRIC, 0);
		add_row(make_sphere(0, 0, 0, 4), make_sphere(3, 4, 0, 4), TOUCHING, 3);
		// exact tangent
		add_row(make_sphere(0, 0, 0, 3), make_sphere(0, 0, 5, 2), TOUCHING, 0);
		add_row(make_sphere(0, 0, 0, 2), make_sphere(1, 1, 1, 2), TOUCHING, 3);
		add_row(make_sphere(-10, -20, -30, 20), make_sphere(-1, -8, -30, 10), TOUCHING, 15);
		add_row(make_sphere(-32767, -32767, -32767, 100),
			make_sphere(32767, 32767, 32767, 100), NO_CONTACT, 0);
		add_row(make_sphere(32767, 32767, 32767, 32767),
			make_sphere(32767, 32767, -32767, 32767), TOUCHING, 0);
		add_row(make_sphere(32233, -5, 7, 32767),
			make_sphere(-32767, -5, 7, 32767), TOUCHING, 534);
		// sqrt(600) floors to 24
		add_row(make_sphere(100, 200, 300, 50), make_sphere(110, 190, 320, 40), TOUCHING, 66);
		add_row(make_sphere(-500, 300, -200, 20), make_sphere(-480, 285, -200, 15), TOUCHING, 10);
	endtask

	// back to back, next request as soon as the previous one is taken
	task automatic send_requests();
		int waited;
		for (int n = 0; n < vectors.size(); n++)
		begin
			@(negedge clk);
			req       = vectors[n].req;
			req_valid = 1'b1;
			waited    = 0;
			while (!req_ready)
			begin
				@(negedge clk);
				waited++;
				if (waited > READY_LIMIT)
				begin
					error_count++;
					$display("timeout: req_ready never came for request %0d", n);
					$display("test failed");
					$fatal(1, "req_ready wait expired");
				end
			end
		end
		@(negedge clk);
		req_valid = 1'b0;
	endtask

	task automatic collect_results();
		int           waited;
		logic         taken;
		logic         held;
		collide_res_t held_res;
		for (int idx = 0; idx < vectors.size(); idx++)
		begin
			waited = 0;
			taken  = 1'b0;
			held   = 1'b0;
			while (!taken)
			begin
				@(negedge clk);
				res_ready = ($urandom % 100) >= 30;
				// a stalled result must not move
				if (held)
					assert (res_valid && res == held_res)
					else
					begin
						error_count++;
						$display("FAILED at %0t: result %0d changed while stalled", $time, idx);
						$display("test failed");
						$fatal(1, "unstable result");
					end
				taken    = res_valid && res_ready;
				held     = res_valid && !res_ready;
				held_res = res;
				waited++;
				if (!taken && waited > RESULT_LIMIT)
				begin
					error_count++;
					$display("timeout: res_valid never came for result %0d", idx);
					$display("test failed");
					$fatal(1, "res_valid wait expired");
				end
			end
			assert (res == vectors[idx].expected)
			else
			begin
				error_count++;
				$display("FAILED at %0t: result %0d kind %0d depth %0d, expected kind %0d depth %0d",
					$time, idx, res.kind, res.depth,
					vectors[idx].expected.kind, vectors[idx].expected.depth);
				$display("test failed");
				$fatal(1, "result mismatch");
			end
		end
	endtask

	// no extra result may follow the last one
	task automatic check_idle();
		res_ready = 1'b1;
		repeat (QUIET_CYCLES)
		begin
			@(negedge clk);
			assert (!res_valid)
			else
			begin
				error_count++;
				$display("FAILED at %0t: unexpected extra result", $time);
				$display("test failed");
				$fatal(1, "extra result");
			end
		end
	endtask

	initial
	begin
		void'($urandom(32'ha7b0));
		error_count = 0;
		clk0        = 1'b1;
		req         = '0;
		req_valid   = 1'b0;
		res_ready   = 1'b0;
		load_table();
		repeat (16) @(posedge clk);
		@(negedge clk);
		clk0 = 1'b0;
		fork
			send_requests();
			collect_results();
		join
		check_idle();
		if (error_count == 0)
		begin
			$display("test passed");
			$finish;
		end
		else
		begin
			$display("test failed");
			$fatal(1, "errors found");
		end
	end

endmodule

//--- all.f
design/collide_pkg.sv
design/dist_sq_unit.sv
design/isqrt_seq.sv
design/collide_ctrl.sv
design/sphere_collide_top.sv
tb/tb_sphere_collide.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --Wno-fatal
TOP       = tb_sphere_collide
FILELIST  = all.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all lint clean

all:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^test passed$$" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -Wall --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
